/* sw_pkg.sv */
package sw_pkg;

  // array sizes
  localparam int REF_MAX_LEN  = 16;
  localparam int READ_MAX_LEN = 16;  // also the number of cells
  localparam int SCORE_W      = 10;

  // one nucleotide code
  typedef logic [1:0] base_t;

  typedef logic signed [SCORE_W-1:0] score_t;

  // packed sequences, base j at bits 2j+1..2j
  typedef logic [2*REF_MAX_LEN-1:0]  ref_seq_t;
  typedef logic [2*READ_MAX_LEN-1:0] read_seq_t;

  // lengths are 1-based
  typedef logic [$clog2(REF_MAX_LEN):0]  ref_len_t;
  typedef logic [$clog2(READ_MAX_LEN):0] read_len_t;

  // indices are 0-based
  typedef logic [$clog2(REF_MAX_LEN)-1:0]  col_t;
  typedef logic [$clog2(READ_MAX_LEN)-1:0] row_t;

  // compute phase runs up to ref len + READ_MAX_LEN cycles
  typedef logic [$clog2(REF_MAX_LEN + READ_MAX_LEN):0] count_t;

  // affine scoring
  localparam score_t MATCH_SCORE    = score_t'(1);
  localparam score_t MISMATCH_SCORE = score_t'(-4);
  localparam score_t GAP_OPEN       = score_t'(-6);
  localparam score_t GAP_EXTEND     = score_t'(-1);

endpackage

/* sw_cell.sv */
module sw_cell (
  input  logic           clk,
  input  logic           rst,
  input  logic           i_clear,
  input  logic           i_row_en,
  input  sw_pkg::base_t  i_a_base,    // reference base from previous cell
  input  logic           i_a_valid,
  input  sw_pkg::base_t  i_b_base,    // read base of this row
  input  sw_pkg::score_t i_h_top,     // H(r-1, c)
  input  sw_pkg::score_t i_i_top,     // I(r-1, c)
  input  sw_pkg::score_t i_h_diag,    // H(r-1, c-1)
  output sw_pkg::base_t  o_a_base,
  output logic           o_a_valid,
  output sw_pkg::score_t o_h,
  output sw_pkg::score_t o_i,
  output sw_pkg::score_t o_h_diag,
  output sw_pkg::score_t o_best,
  output sw_pkg::col_t   o_best_col
);

  sw_pkg::score_t h_q;
  sw_pkg::score_t i_q;
  sw_pkg::score_t d_q;
  sw_pkg::score_t hd_q;
  sw_pkg::score_t best_q;
  sw_pkg::col_t   col_q;
  sw_pkg::col_t   best_col_q;

  sw_pkg::score_t i_new;
  sw_pkg::score_t d_new;
  sw_pkg::score_t h_new;
  sw_pkg::score_t sub;
  logic           step;

  function automatic sw_pkg::score_t smax(input sw_pkg::score_t a, input sw_pkg::score_t b);
    return (a > b) ? a : b;
  endfunction

  assign step = i_a_valid & i_row_en;  // rows past the read length stay idle

  always_comb
  begin
    sub   = (i_a_base == i_b_base) ? sw_pkg::MATCH_SCORE : sw_pkg::MISMATCH_SCORE;
    // gap from above
    i_new = smax(smax(i_h_top + sw_pkg::GAP_OPEN, i_i_top + sw_pkg::GAP_EXTEND), '0);
    // gap from the left in its own row
    d_new = smax(smax(h_q + sw_pkg::GAP_OPEN, d_q + sw_pkg::GAP_EXTEND), '0);
    h_new = smax(smax(i_h_diag + sub, '0), smax(i_new, d_new));
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      h_q        <= '0;
      i_q        <= '0;
      d_q        <= '0;
      hd_q       <= '0;
      col_q      <= '0;
      best_q     <= '0;
      best_col_q <= '0;
    end
    else if (i_clear)
    begin
      h_q        <= '0;
      i_q        <= '0;
      d_q        <= '0;
      hd_q       <= '0;
      col_q      <= '0;
      best_q     <= '0;
      best_col_q <= '0;
    end
    else if (step)
    begin
      h_q   <= h_new;
      i_q   <= i_new;
      d_q   <= d_new;
      hd_q  <= h_q;  // becomes diagonal for the row below
      col_q <= col_q + 1'b1;
      if (h_new > best_q)  // strict so ties keep the first column
      begin
        best_q     <= h_new;
        best_col_q <= col_q;
      end
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      o_a_valid <= 1'b0;
    else
      o_a_valid <= i_a_valid;
  end

  always_ff @(posedge clk)
  begin
    o_a_base <= i_a_base;
  end

  assign o_h        = h_q;
  assign o_i        = i_q;
  assign o_h_diag   = hd_q;
  assign o_best     = best_q;
  assign o_best_col = best_col_q;

  // scores from the row above arrive clamped at zero
  a_top_nonneg: assert property (@(posedge clk) disable iff (rst)
    step |-> (i_h_top >= 0) && (i_i_top >= 0) && (i_h_diag >= 0));

endmodule

/* sw_control.sv */
module sw_control (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_valid,
  input  sw_pkg::ref_seq_t                i_ref_seq,
  input  sw_pkg::read_seq_t               i_read_seq,
  input  sw_pkg::ref_len_t                i_ref_len,
  input  sw_pkg::read_len_t               i_read_len,
  input  logic                            i_ready,
  input  logic                            i_scan_done,
  output logic                            o_ready,
  output logic                            o_valid,
  output logic                            o_clear,
  output logic [sw_pkg::READ_MAX_LEN-1:0] o_row_en,
  output sw_pkg::base_t                   o_ref_base,
  output logic                            o_ref_base_valid,
  output sw_pkg::read_seq_t               o_read_seq,
  output sw_pkg::read_len_t               o_read_len,
  output logic                            o_scan_start
);

  typedef enum logic [2:0] {
    s_idle,
    s_load,
    s_compute,
    s_scan,
    s_done
  } state_t;

  state_t            state;
  state_t            state_n;
  sw_pkg::count_t    cnt;
  sw_pkg::ref_seq_t  ref_shift;  // base 0 sits in the low bits
  sw_pkg::read_seq_t read_q;
  sw_pkg::ref_len_t  ref_len_q;
  sw_pkg::read_len_t read_len_q;
  logic              accept;
  logic              drain_last;

  assign accept     = i_valid & o_ready;
  // last compute cycle once the last base has left the last cell
  assign drain_last = (cnt == {1'b0, ref_len_q} + sw_pkg::count_t'(sw_pkg::READ_MAX_LEN - 1));

  always_comb
  begin
    state_n = state;
    case (state)
      s_idle:    if (accept) state_n = s_load;
      s_load:    state_n = s_compute;
      s_compute: if (drain_last) state_n = s_scan;
      s_scan:    if (i_scan_done) state_n = s_done;
      s_done:    if (i_ready) state_n = s_idle;
      default:   state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= s_idle;
      cnt   <= '0;
    end
    else
    begin
      state <= state_n;
      if (state == s_compute)
        cnt <= cnt + 1'b1;
      else
        cnt <= '0;
    end
  end

  // sequence and length capture
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      ref_shift  <= i_ref_seq;
      read_q     <= i_read_seq;
      ref_len_q  <= i_ref_len;
      read_len_q <= i_read_len;
    end
    else if (o_ref_base_valid)
      ref_shift <= ref_shift >> 2;  // next base into the chain
  end

  always_comb
  begin
    for (int r = 0; r < sw_pkg::READ_MAX_LEN; r++)
      o_row_en[r] = (r < read_len_q);
  end

  assign o_ready          = (state == s_idle);
  assign o_valid          = (state == s_done);
  assign o_clear          = (state == s_load);  // one cycle after acceptance
  assign o_ref_base       = ref_shift[1:0];
  assign o_ref_base_valid = (state == s_compute) && ({1'b0, cnt} < {2'b0, ref_len_q});
  assign o_read_seq       = read_q;
  assign o_read_len       = read_len_q;
  assign o_scan_start     = (state == s_compute) && drain_last;

  // the scanner may only finish while the FSM waits for it
  a_done_in_scan: assert property (@(posedge clk) disable iff (rst)
    i_scan_done |-> (state == s_scan));

  a_len_range: assert property (@(posedge clk) disable iff (rst)
    accept |-> (i_ref_len >= 1) && (i_ref_len <= sw_pkg::REF_MAX_LEN) &&
               (i_read_len >= 1) && (i_read_len <= sw_pkg::READ_MAX_LEN));

endmodule

/* sw_max_scan.sv */
module sw_max_scan (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_clear,
  input  logic              i_start,
  input  sw_pkg::read_len_t i_read_len,
  input  sw_pkg::score_t    i_best [sw_pkg::READ_MAX_LEN],
  input  sw_pkg::col_t      i_best_col [sw_pkg::READ_MAX_LEN],
  output logic              o_done,
  output sw_pkg::score_t    o_score,
  output sw_pkg::row_t      o_row,
  output sw_pkg::col_t      o_col
);

  logic           busy;
  logic           last_row;
  sw_pkg::row_t   idx;
  sw_pkg::score_t score_q;
  sw_pkg::row_t   row_q;
  sw_pkg::col_t   col_q;

  assign last_row = ({1'b0, idx} == i_read_len - 1'b1);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      idx     <= '0;
      o_done  <= 1'b0;
      score_q <= '0;
      row_q   <= '0;
      col_q   <= '0;
    end
    else
    begin
      o_done <= 1'b0;  // single cycle pulse
      if (i_clear)
      begin
        score_q <= '0;
        row_q   <= '0;
        col_q   <= '0;
      end
      if (i_start)
      begin
        busy <= 1'b1;
        idx  <= '0;
      end
      else if (busy)
      begin
        // strict compare, earliest row wins a tie
        if (i_best[idx] > score_q)
        begin
          score_q <= i_best[idx];
          row_q   <= idx;
          col_q   <= i_best_col[idx];
        end
        if (last_row)
        begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
        else
          idx <= idx + 1'b1;
      end
    end
  end

  assign o_score = score_q;
  assign o_row   = row_q;
  assign o_col   = col_q;

endmodule

/* sw_core.sv */
module sw_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  output logic              o_ready,
  input  sw_pkg::ref_seq_t  i_ref_seq,
  input  sw_pkg::read_seq_t i_read_seq,
  input  sw_pkg::ref_len_t  i_ref_len,
  input  sw_pkg::read_len_t i_read_len,
  output logic              o_valid,
  input  logic              i_ready,
  output sw_pkg::score_t    o_score,
  output sw_pkg::row_t      o_row,
  output sw_pkg::col_t      o_col
);

  localparam int N = sw_pkg::READ_MAX_LEN;

  logic              clear;
  logic              scan_start;
  logic              scan_done;
  logic [N-1:0]      row_en;
  sw_pkg::read_seq_t read_seq;
  sw_pkg::read_len_t read_len;

  // chain links, element r feeds cell r
  sw_pkg::base_t     a_base [N+1];
  logic              a_valid [N+1];
  sw_pkg::score_t    h_chain [N+1];
  sw_pkg::score_t    i_chain [N+1];
  sw_pkg::score_t    hd_chain [N+1];

  sw_pkg::score_t    best [N];
  sw_pkg::col_t      best_col [N];

  // row 0 sees an all-zero row above
  assign h_chain[0]  = '0;
  assign i_chain[0]  = '0;
  assign hd_chain[0] = '0;

  sw_control u_control (
    .clk              (clk),
    .rst              (rst),
    .i_valid          (i_valid),
    .i_ref_seq        (i_ref_seq),
    .i_read_seq       (i_read_seq),
    .i_ref_len        (i_ref_len),
    .i_read_len       (i_read_len),
    .i_ready          (i_ready),
    .i_scan_done      (scan_done),
    .o_ready          (o_ready),
    .o_valid          (o_valid),
    .o_clear          (clear),
    .o_row_en         (row_en),
    .o_ref_base       (a_base[0]),
    .o_ref_base_valid (a_valid[0]),
    .o_read_seq       (read_seq),
    .o_read_len       (read_len),
    .o_scan_start     (scan_start)
  );

  for (genvar r = 0; r < N; r++)
  begin : g_cell
    sw_cell u_cell (
      .clk        (clk),
      .rst        (rst),
      .i_clear    (clear),
      .i_row_en   (row_en[r]),
      .i_a_base   (a_base[r]),
      .i_a_valid  (a_valid[r]),
      .i_b_base   (read_seq[2*r +: 2]),
      .i_h_top    (h_chain[r]),
      .i_i_top    (i_chain[r]),
      .i_h_diag   (hd_chain[r]),
      .o_a_base   (a_base[r+1]),
      .o_a_valid  (a_valid[r+1]),
      .o_h        (h_chain[r+1]),
      .o_i        (i_chain[r+1]),
      .o_h_diag   (hd_chain[r+1]),
      .o_best     (best[r]),
      .o_best_col (best_col[r])
    );
  end

  sw_max_scan u_max_scan (
    .clk        (clk),
    .rst        (rst),
    .i_clear    (clear),
    .i_start    (scan_start),
    .i_read_len (read_len),
    .i_best     (best),
    .i_best_col (best_col),
    .o_done     (scan_done),
    .o_score    (o_score),
    .o_row      (o_row),
    .o_col      (o_col)
  );

endmodule

/* tb_sw_core.sv */
module tb_sw_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS   = 60;
  localparam int MAX_STALL   = 8;  // longest i_ready low stretch
  localparam int LATENCY_MAX = sw_pkg::REF_MAX_LEN + 2 * sw_pkg::READ_MAX_LEN + 4;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (LATENCY_MAX + MAX_STALL) * 2;

  logic              clk = 1'b0;
  logic              rst;
  logic              i_valid;
  logic              o_ready;
  sw_pkg::ref_seq_t  i_ref_seq;
  sw_pkg::read_seq_t i_read_seq;
  sw_pkg::ref_len_t  i_ref_len;
  sw_pkg::read_len_t i_read_len;
  logic              o_valid;
  logic              i_ready;
  sw_pkg::score_t    o_score;
  sw_pkg::row_t      o_row;
  sw_pkg::col_t      o_col;

  int   seed = 32'h4db7_091c;
  int   done_count = 0;
  logic in_flight;  // high from acceptance until the result is taken

  // pending requests with the oldest first
  logic [31:0] ref_q [$];
  logic [31:0] read_q [$];
  int          rlen_q [$];
  int          qlen_q [$];
  int          stall_q [$];
  string       name_q [$];

  sw_core i_sw_core (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .i_ref_seq  (i_ref_seq),
    .i_read_seq (i_read_seq),
    .i_ref_len  (i_ref_len),
    .i_read_len (i_read_len),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .o_score    (o_score),
    .o_row      (o_row),
    .o_col      (o_col)
  );

  always #10 clk = ~clk;

  task automatic end_in_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    end_in_failure();
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual)
    begin
      $display("** Error: %s: expected %0d, actual %0d", what, expected, actual);
      end_in_failure();
    end
  endtask

  function automatic int larger(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  function automatic int pick_len(input int max_len);
    return int'($unsigned($random(seed)) % max_len) + 1;
  endfunction

  // full matrix with zero borders
  // row-major scan with a strict compare keeps the earliest row and column
  function automatic void ref_align(input logic [31:0] rs, input logic [31:0] qs,
                                    input int rl, input int ql,
                                    output int score, output int row, output int col);
    int hm [sw_pkg::READ_MAX_LEN+1][sw_pkg::REF_MAX_LEN+1];
    int im [sw_pkg::READ_MAX_LEN+1][sw_pkg::REF_MAX_LEN+1];
    int dm [sw_pkg::READ_MAX_LEN+1][sw_pkg::REF_MAX_LEN+1];
    int sub;
    score = 0;
    row   = 0;
    col   = 0;
    for (int r = 0; r <= sw_pkg::READ_MAX_LEN; r++)
      for (int c = 0; c <= sw_pkg::REF_MAX_LEN; c++)
      begin
        hm[r][c] = 0;
        im[r][c] = 0;
        dm[r][c] = 0;
      end
    for (int r = 0; r < ql; r++)
      for (int c = 0; c < rl; c++)
      begin
        sub = (rs[2*c +: 2] == qs[2*r +: 2]) ? int'(sw_pkg::MATCH_SCORE)
                                             : int'(sw_pkg::MISMATCH_SCORE);
        // matrix cell (r, c) lives at [r+1][c+1]
        im[r+1][c+1] = larger(larger(hm[r][c+1] + int'(sw_pkg::GAP_OPEN),
                                     im[r][c+1] + int'(sw_pkg::GAP_EXTEND)), 0);
        dm[r+1][c+1] = larger(larger(hm[r+1][c] + int'(sw_pkg::GAP_OPEN),
                                     dm[r+1][c] + int'(sw_pkg::GAP_EXTEND)), 0);
        hm[r+1][c+1] = larger(larger(hm[r][c] + sub, 0), larger(im[r+1][c+1], dm[r+1][c+1]));
        if (hm[r+1][c+1] > score)
        begin
          score = hm[r+1][c+1];
          row   = r;
          col   = c;
        end
      end
  endfunction

  // sanity check of the model on a hand worked case
  task automatic expect_model(input string name, input logic [31:0] rs, input logic [31:0] qs,
                              input int rl, input int ql, input int s, input int r, input int c);
    int es;
    int er;
    int ec;
    ref_align(rs, qs, rl, ql, es, er, ec);
    check_value({name, " model score"}, s, es);
    check_value({name, " model row"}, r, er);
    check_value({name, " model col"}, c, ec);
  endtask

  // starts and returns on a falling edge
  task automatic send_job(input string name, input logic [31:0] rs, input logic [31:0] qs,
                          input int rl, input int ql);
    int stall;
    stall = int'($unsigned($random(seed)) % (MAX_STALL + 1));
    while (!o_ready)
      @(negedge clk);
    i_valid    = 1'b1;
    i_ref_seq  = rs;
    i_read_seq = qs;
    i_ref_len  = sw_pkg::ref_len_t'(rl);
    i_read_len = sw_pkg::read_len_t'(ql);
    @(negedge clk);  // accepted on the edge in between
    i_valid = 1'b0;
    ref_q.push_back(rs);
    read_q.push_back(qs);
    rlen_q.push_back(rl);
    qlen_q.push_back(ql);
    stall_q.push_back(stall);
    name_q.push_back(name);
  endtask

  always @(posedge clk or posedge rst)
  begin
    if (rst)
      in_flight <= 1'b0;
    else if (i_valid && o_ready)
      in_flight <= 1'b1;
    else if (o_valid && i_ready)
      in_flight <= 1'b0;
  end

  initial
  begin : stimulus
    int          id_lens [4];
    logic [31:0] s;
    int          rl;
    int          ql;
    id_lens    = '{1, 5, 11, 16};
    rst        = 1'b1;
    i_valid    = 1'b0;
    i_ref_seq  = '0;
    i_read_seq = '0;
    i_ref_len  = '0;
    i_read_len = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("reset o_ready", 1, int'(o_ready));
    check_value("reset o_valid", 0, int'(o_valid));

    for (int k = 0; k < 4; k++)
    begin
      s = $random(seed);
      expect_model($sformatf("identical n=%0d", id_lens[k]), s, s, id_lens[k], id_lens[k],
                   id_lens[k], id_lens[k] - 1, id_lens[k] - 1);
      send_job($sformatf("identical n=%0d", id_lens[k]), s, s, id_lens[k], id_lens[k]);
    end

    // ACGT twice gives equal scores at two places
    expect_model("repeat in reference", 32'h0000_e4e4, 32'h0000_00e4, 8, 4, 4, 3, 3);
    send_job("repeat in reference", 32'h0000_e4e4, 32'h0000_00e4, 8, 4);
    expect_model("repeat in read", 32'h0000_00e4, 32'h0000_e4e4, 4, 8, 4, 3, 3);
    send_job("repeat in read", 32'h0000_00e4, 32'h0000_e4e4, 4, 8);

    rl = pick_len(sw_pkg::REF_MAX_LEN);
    ql = pick_len(sw_pkg::READ_MAX_LEN);
    expect_model("no match A/C", 32'h0000_0000, 32'h5555_5555, rl, ql, 0, 0, 0);
    send_job("no match A/C", 32'h0000_0000, 32'h5555_5555, rl, ql);
    expect_model("no match G/T", 32'haaaa_aaaa, 32'hffff_ffff, 16, 16, 0, 0, 0);
    send_job("no match G/T", 32'haaaa_aaaa, 32'hffff_ffff, 16, 16);

    for (int k = 8; k < NUM_TESTS; k++)
    begin
      s  = $random(seed);
      rl = pick_len(sw_pkg::REF_MAX_LEN);
      ql = pick_len(sw_pkg::READ_MAX_LEN);
      send_job($sformatf("random %0d", k), s, $random(seed), rl, ql);
    end

    wait (done_count == NUM_TESTS);
    repeat (5) @(negedge clk);
    if (ref_q.size() == 0 && !o_valid && o_ready)
      $display("all tests passed");
    else
      report_problem("DUT did not return to idle after the last result");
    $finish;
  end

  initial
  begin : compare
    logic [31:0] rs;
    logic [31:0] qs;
    int          rl;
    int          ql;
    int          stall;
    string       name;
    int          es;
    int          er;
    int          ec;
    int          got_score;
    int          got_row;
    int          got_col;
    i_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      if (in_flight && o_ready)
        report_problem("o_ready went high while an alignment was in flight");
      if (o_valid)
      begin
        if (ref_q.size() == 0)
          report_problem("o_valid rose with no request pending");
        rs    = ref_q.pop_front();
        qs    = read_q.pop_front();
        rl    = rlen_q.pop_front();
        ql    = qlen_q.pop_front();
        stall = stall_q.pop_front();
        name  = name_q.pop_front();
        ref_align(rs, qs, rl, ql, es, er, ec);
        got_score = int'(o_score);
        got_row   = int'(o_row);
        got_col   = int'(o_col);
        check_value({name, " score"}, es, got_score);
        check_value({name, " row"}, er, got_row);
        check_value({name, " col"}, ec, got_col);
        repeat (stall)
        begin
          @(negedge clk);
          if (!o_valid)
            report_problem({name, ": o_valid dropped while i_ready was low"});
          check_value({name, " held score"}, got_score, int'(o_score));
          check_value({name, " held row"}, got_row, int'(o_row));
          check_value({name, " held col"}, got_col, int'(o_col));
        end
        i_ready = 1'b1;
        @(negedge clk);  // result taken on this edge
        i_ready = 1'b0;
        if (o_valid || !o_ready)
          report_problem({name, ": handshake did not return to idle after the result"});
        done_count++;
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("error: watchdog expired before every result was checked");
    end_in_failure();
  end

endmodule

/* sw_core.f */
sw_pkg.sv
sw_cell.sv
sw_control.sv
sw_max_scan.sv
sw_core.sv
tb_sw_core.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sw_core \
  -f sw_core.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log 2>/dev/null \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }
